//--- logic/addPipe.sv
module addPipe (
	input  logic clk,
	input  logic rst,
	input  fpPkg::halfWord a,
	input  fpPkg::halfWord b,
	input  logic op,
	input  logic inValid,
	output logic normSign,
	output logic signed [fpPkg::ExpWidth:0] normExp,
	output logic [fpPkg::SigWidth-1:0] normMan,
	output logic [fpPkg::GrsWidth-1:0] normGrs,
	output logic zeroSum,
	output logic normValid
);

	// Stage 1 to 2
	logic [fpPkg::SigWidth+fpPkg::GrsWidth-1:0] bigSig;
	logic [fpPkg::SigWidth+fpPkg::GrsWidth-1:0] smallSig;
	logic [fpPkg::ExpWidth-1:0] bigExp;
	logic resSign;
	logic effSub;
	logic alignValid;

	// Stage 2 to 3
	logic [fpPkg::SumWidth-1:0] sum;
	logic [fpPkg::ExpWidth-1:0] sumExp;
	logic sumSign;
	logic sumValid;

	operandAlign alignStage (
		.clk, .rst, .a, .b, .op, .inValid,
		.bigSig, .smallSig, .bigExp, .resSign, .effSub, .alignValid
	);

	mantissaAdd addStage (
		.clk, .rst, .bigSig, .smallSig, .bigExp, .resSign, .effSub, .alignValid,
		.sum, .sumExp, .sumSign, .sumValid
	);

	sumNormalize normStage (
		.clk, .rst, .sum, .sumExp, .sumSign, .sumValid,
		.normSign, .normExp, .normMan, .normGrs, .zeroSum, .normValid
	);

endmodule

//--- logic/fpAddSub.sv
module fpAddSub (
	input  logic clk,
	input  logic rst,
	input  fpPkg::halfWord a,
	input  fpPkg::halfWord b,
	input  logic op,                 // 0 add, 1 sub
	input  logic inValid,
	output fpPkg::halfWord result,
	output fpPkg::flagVec flags,
	output logic outValid            // Four edges after inValid
);

	// Datapath into round stage
	logic normSign;
	logic signed [fpPkg::ExpWidth:0] normExp;
	logic [fpPkg::SigWidth-1:0] normMan;
	logic [fpPkg::GrsWidth-1:0] normGrs;
	logic zeroSum;
	logic normValid;

	// Special path, already delayed to line up
	logic isSpecial;
	fpPkg::halfWord specialResult;
	logic specialInvalid;

	addPipe datapath (
		.clk, .rst, .a, .b, .op, .inValid,
		.normSign, .normExp, .normMan, .normGrs, .zeroSum, .normValid
	);

	specialCases specials (
		.clk, .rst, .a, .b, .op,
		.isSpecial, .specialResult, .specialInvalid
	);

	roundPack packStage (
		.clk, .rst, .normSign, .normExp, .normMan, .normGrs, .zeroSum, .normValid,
		.isSpecial, .specialResult, .specialInvalid,
		.result, .flags, .outValid
	);

endmodule

//--- logic/fpPkg.sv
package fpPkg;

	// Half precision field layout
	localparam int ExpWidth = 5;   // Exponent field
	localparam int ManWidth = 10;  // Stored fraction
	localparam int HalfWidth = 1 + ExpWidth + ManWidth;
	localparam int ExpMax = (1 << ExpWidth) - 1; // All-ones exponent, NaN or Inf

	// Datapath widths
	localparam int SigWidth = ManWidth + 1;             // Hidden bit plus fraction
	localparam int GrsWidth = 3;                        // Guard, round, sticky
	localparam int SumWidth = SigWidth + GrsWidth + 1;  // One extra carry bit
	// Right shifter width, room for any exponent difference
	localparam int AlignWidth = SigWidth + (1 << ExpWidth);

	// Input to output latency
	localparam int PipeDepth = 4;

	typedef logic [HalfWidth-1:0] halfWord;

	// Exception flags, overflow at the MSB
	typedef logic [3:0] flagVec;

	localparam int FlagOverflow = 3;
	localparam int FlagUnderflow = 2;
	localparam int FlagInvalid = 1;
	localparam int FlagInexact = 0;

	// Quiet NaN, plus sign, top fraction bit set
	localparam halfWord CanonNaN = {
		1'b0,
		{ExpWidth{1'b1}},
		1'b1,
		{(ManWidth-1){1'b0}}
	};

endpackage

//--- logic/mantissaAdd.sv
module mantissaAdd (
	input  logic clk,
	input  logic rst,
	input  logic [fpPkg::SigWidth+fpPkg::GrsWidth-1:0] bigSig,
	input  logic [fpPkg::SigWidth+fpPkg::GrsWidth-1:0] smallSig,
	input  logic [fpPkg::ExpWidth-1:0] bigExp,
	input  logic resSign,
	input  logic effSub,
	input  logic alignValid,
	output logic [fpPkg::SumWidth-1:0] sum,     // Carry, significand, GRS
	output logic [fpPkg::ExpWidth-1:0] sumExp,
	output logic sumSign,
	output logic sumValid
);

	logic [fpPkg::SumWidth-1:0] nextSum;

	// Larger operand first, so the difference never goes negative
	assign nextSum = effSub ? ({1'b0, bigSig} - {1'b0, smallSig})
		: ({1'b0, bigSig} + {1'b0, smallSig});

	always_ff @(posedge clk) begin
		sum <= nextSum;
		sumExp <= bigExp;
		sumSign <= resSign;  // Sign already settled in stage 1
	end

	always_ff @(posedge clk) begin
		if (rst)
			sumValid <= 1'b0;
		else
			sumValid <= alignValid;
	end

endmodule

//--- logic/operandAlign.sv
module operandAlign (
	input  logic clk,
	input  logic rst,
	input  fpPkg::halfWord a,
	input  fpPkg::halfWord b,
	input  logic op,                  // 0 add, 1 sub
	input  logic inValid,
	output logic [fpPkg::SigWidth+fpPkg::GrsWidth-1:0] bigSig,   // Larger significand, GRS clear
	output logic [fpPkg::SigWidth+fpPkg::GrsWidth-1:0] smallSig, // Aligned smaller one
	output logic [fpPkg::ExpWidth-1:0] bigExp,                   // Common exponent
	output logic resSign,
	output logic effSub,
	output logic alignValid
);

	logic [fpPkg::ExpWidth-1:0] expA;
	logic [fpPkg::ExpWidth-1:0] expB;
	logic zeroA;
	logic zeroB;
	logic [fpPkg::SigWidth-1:0] sigA;
	logic [fpPkg::SigWidth-1:0] sigB;
	logic [fpPkg::HalfWidth-2:0] magA;  // Magnitude with zero exponent flushed
	logic [fpPkg::HalfWidth-2:0] magB;
	logic aBig;                          // Ties go to a
	logic [fpPkg::ExpWidth-1:0] shiftAmt;
	logic [fpPkg::AlignWidth-1:0] wideSmall;
	logic nextEffSub;
	logic nextSign;

	assign expA = a[fpPkg::HalfWidth-2 -: fpPkg::ExpWidth];
	assign expB = b[fpPkg::HalfWidth-2 -: fpPkg::ExpWidth];
	assign zeroA = (expA == '0);          // Subnormals flushed too
	assign zeroB = (expB == '0);
	assign sigA = zeroA ? '0 : {1'b1, a[fpPkg::ManWidth-1:0]};
	assign sigB = zeroB ? '0 : {1'b1, b[fpPkg::ManWidth-1:0]};
	assign magA = zeroA ? '0 : a[fpPkg::HalfWidth-2:0];
	assign magB = zeroB ? '0 : b[fpPkg::HalfWidth-2:0];

	assign aBig = (magA >= magB);
	assign shiftAmt = aBig ? (expA - expB) : (expB - expA);
	assign nextEffSub = op ^ a[fpPkg::HalfWidth-1] ^ b[fpPkg::HalfWidth-1];

	// Smaller significand at the top, everything shifted out lands below the GR bits
	assign wideSmall = {aBig ? sigB : sigA, {(fpPkg::AlignWidth-fpPkg::SigWidth){1'b0}}} >> shiftAmt;

	always_comb begin
		if (nextEffSub && magA == magB)
			nextSign = 1'b0;                                  // Exact cancellation is +0
		else if (zeroA && zeroB)
			nextSign = a[fpPkg::HalfWidth-1] & b[fpPkg::HalfWidth-1] & ~op;
		else if (aBig)
			nextSign = a[fpPkg::HalfWidth-1];
		else
			nextSign = b[fpPkg::HalfWidth-1] ^ op;            // b negated for sub
	end

	always_ff @(posedge clk) begin
		bigSig <= {aBig ? sigA : sigB, {fpPkg::GrsWidth{1'b0}}};
		smallSig <= {wideSmall[fpPkg::AlignWidth-1 -: fpPkg::SigWidth+fpPkg::GrsWidth-1],
			|wideSmall[fpPkg::AlignWidth-fpPkg::SigWidth-fpPkg::GrsWidth:0]}; // Sticky
		bigExp <= aBig ? expA : expB;
		resSign <= nextSign;
		effSub <= nextEffSub;
	end

	always_ff @(posedge clk) begin
		if (rst)
			alignValid <= 1'b0;
		else
			alignValid <= inValid;
	end

endmodule

//--- logic/roundPack.sv
module roundPack (
	input  logic clk,
	input  logic rst,
	input  logic normSign,
	input  logic signed [fpPkg::ExpWidth:0] normExp,
	input  logic [fpPkg::SigWidth-1:0] normMan,
	input  logic [fpPkg::GrsWidth-1:0] normGrs,
	input  logic zeroSum,
	input  logic normValid,
	input  logic isSpecial,
	input  fpPkg::halfWord specialResult,
	input  logic specialInvalid,
	output fpPkg::halfWord result,
	output fpPkg::flagVec flags,
	output logic outValid
);

	logic roundUp;
	logic [fpPkg::SigWidth:0] rounded;               // Room for a rounding carry
	logic signed [fpPkg::ExpWidth+1:0] roundExp;
	logic inexact;
	fpPkg::halfWord nextResult;
	fpPkg::flagVec nextFlags;

	// Nearest even, a tie rounds up only from an odd LSB
	assign roundUp = normGrs[2] & (normGrs[1] | normGrs[0] | normMan[0]);
	assign rounded = {1'b0, normMan} + roundUp;
	assign roundExp = normExp + $signed({1'b0, rounded[fpPkg::SigWidth]}); // Carry bumps exponent
	assign inexact = |normGrs;

	always_comb begin
		nextFlags = '0;
		if (isSpecial) begin
			nextResult = specialResult;                  // Special path wins
			nextFlags[fpPkg::FlagInvalid] = specialInvalid;
		end else if (zeroSum) begin
			nextResult = {normSign, {(fpPkg::HalfWidth-1){1'b0}}};  // Sign from stage 1 rule
		end else if (normExp <= 0) begin
			nextResult = {normSign, {(fpPkg::HalfWidth-1){1'b0}}};  // Flush to zero
			nextFlags[fpPkg::FlagUnderflow] = 1'b1;
			nextFlags[fpPkg::FlagInexact] = 1'b1;
		end else if (roundExp >= fpPkg::ExpMax) begin
			nextResult = {normSign, {fpPkg::ExpWidth{1'b1}}, {fpPkg::ManWidth{1'b0}}};
			nextFlags[fpPkg::FlagOverflow] = 1'b1;
			nextFlags[fpPkg::FlagInexact] = 1'b1;
		end else begin
			// Fraction bits are zero after a rounding carry, no shift needed
			nextResult = {normSign, roundExp[fpPkg::ExpWidth-1:0], rounded[fpPkg::ManWidth-1:0]};
			nextFlags[fpPkg::FlagInexact] = inexact;
		end
	end

	// Outputs hold between pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			flags <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= normValid;
			if (normValid) begin
				result <= nextResult;
				flags <= nextFlags;
			end
		end
	end

endmodule

//--- logic/specialCases.sv
module specialCases (
	input  logic clk,
	input  logic rst,
	input  fpPkg::halfWord a,
	input  fpPkg::halfWord b,
	input  logic op,
	output logic isSpecial,                // NaN or Inf on an input
	output fpPkg::halfWord specialResult,
	output logic specialInvalid
);

	localparam int Depth = fpPkg::PipeDepth - 1;  // Matches the three datapath stages

	logic nanA;
	logic nanB;
	logic infA;
	logic infB;
	logic anyNaN;
	fpPkg::halfWord nextResult;
	logic [Depth-1:0] specialPipe;
	logic [Depth-1:0] invalidPipe;
	fpPkg::halfWord resultPipe [Depth];

	assign nanA = (a[fpPkg::HalfWidth-2 -: fpPkg::ExpWidth] == fpPkg::ExpMax) && (|a[fpPkg::ManWidth-1:0]);
	assign nanB = (b[fpPkg::HalfWidth-2 -: fpPkg::ExpWidth] == fpPkg::ExpMax) && (|b[fpPkg::ManWidth-1:0]);
	assign infA = (a[fpPkg::HalfWidth-2 -: fpPkg::ExpWidth] == fpPkg::ExpMax) && !(|a[fpPkg::ManWidth-1:0]);
	assign infB = (b[fpPkg::HalfWidth-2 -: fpPkg::ExpWidth] == fpPkg::ExpMax) && !(|b[fpPkg::ManWidth-1:0]);

	// Inf minus Inf under effective subtract is invalid
	assign anyNaN = nanA | nanB
		| (infA & infB & (op ^ a[fpPkg::HalfWidth-1] ^ b[fpPkg::HalfWidth-1]));

	always_comb begin
		if (anyNaN)
			nextResult = fpPkg::CanonNaN;
		else if (infA)
			nextResult = {a[fpPkg::HalfWidth-1], {fpPkg::ExpWidth{1'b1}}, {fpPkg::ManWidth{1'b0}}};
		else
			nextResult = {b[fpPkg::HalfWidth-1] ^ op, {fpPkg::ExpWidth{1'b1}},
				{fpPkg::ManWidth{1'b0}}};  // Effective sign of b
	end

	// Shifts every cycle to stay in step with the datapath
	always_ff @(posedge clk) begin
		if (rst) begin
			specialPipe <= '0;
			invalidPipe <= '0;
		end else begin
			specialPipe <= {specialPipe[Depth-2:0], nanA | nanB | infA | infB};
			invalidPipe <= {invalidPipe[Depth-2:0], anyNaN};
		end
	end

	always_ff @(posedge clk) begin
		resultPipe[0] <= nextResult;
		for (int i = 1; i < Depth; i++)
			resultPipe[i] <= resultPipe[i-1];
	end

	assign isSpecial = specialPipe[Depth-1];
	assign specialInvalid = invalidPipe[Depth-1];
	assign specialResult = resultPipe[Depth-1];

endmodule

//--- logic/sumNormalize.sv
module sumNormalize (
	input  logic clk,
	input  logic rst,
	input  logic [fpPkg::SumWidth-1:0] sum,
	input  logic [fpPkg::ExpWidth-1:0] sumExp,
	input  logic sumSign,
	input  logic sumValid,
	output logic normSign,
	output logic signed [fpPkg::ExpWidth:0] normExp,  // May drop to zero or below
	output logic [fpPkg::SigWidth-1:0] normMan,       // Hidden bit included
	output logic [fpPkg::GrsWidth-1:0] normGrs,
	output logic zeroSum,
	output logic normValid
);

	logic [fpPkg::ExpWidth:0] lzCount;      // Leading zeros below the carry bit
	logic found;
	logic [fpPkg::SumWidth-2:0] shifted;
	logic signed [fpPkg::ExpWidth:0] expExt;

	// Priority search for the leading one
	always_comb begin
		lzCount = '0;
		found = 1'b0;
		for (int i = fpPkg::SumWidth-2; i >= 0; i--) begin
			if (!found && sum[i])
				found = 1'b1;
			else if (!found)
				lzCount = lzCount + 1'b1;
		end
	end

	assign shifted = sum[fpPkg::SumWidth-2:0] << lzCount; // All zero sum shifts to zero
	assign expExt = $signed({1'b0, sumExp});

	always_ff @(posedge clk) begin
		normSign <= sumSign;
		zeroSum <= ~|sum;
		if (sum[fpPkg::SumWidth-1]) begin
			// Carry out shifts one place right and folds the lost bit into sticky
			normMan <= sum[fpPkg::SumWidth-1 -: fpPkg::SigWidth];
			normGrs <= {sum[fpPkg::GrsWidth:fpPkg::GrsWidth-1], |sum[fpPkg::GrsWidth-2:0]};
			normExp <= expExt + 1;
		end else begin
			normMan <= shifted[fpPkg::SumWidth-2 -: fpPkg::SigWidth];
			normGrs <= shifted[fpPkg::GrsWidth-1:0];
			normExp <= expExt - $signed(lzCount);  // Count never reaches the sign bit
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			normValid <= 1'b0;
		else
			normValid <= sumValid;
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fpAddSub testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module fpAddSubTb -f src.f -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
	exit 0
fi
exit 1

//--- src.f
logic/fpPkg.sv
logic/operandAlign.sv
logic/mantissaAdd.sv
logic/sumNormalize.sv
logic/addPipe.sv
logic/specialCases.sv
logic/roundPack.sv
logic/fpAddSub.sv
tb/fpAddSub_asserts.sv
tb/fpAddSubChecker.sv
tb/fpAddSubTb.sv

//--- tb/fpAddSubChecker.sv
module fpAddSubChecker (
	input logic clk,
	input logic rst,
	input fpPkg::halfWord a,
	input fpPkg::halfWord b,
	input logic op,
	input logic inValid,
	input fpPkg::halfWord result,
	input fpPkg::flagVec flags,
	input logic outValid,
	input int testNum,
	input logic testDone,
	input logic finalCheck,
	output int errCount,
	output int checkCount
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [52:0] pendQ [$];  // op, a, b, expected flags, expected result
	int testQ [$];           // Test that issued each entry
	int testChecks;
	int testErrs;
	logic [52:0] item;
	int itemTest;

	function automatic string testName(int n);
		case (n)
			1: return "random";
			2: return "cancellation";
			3: return "overflow";
			4: return "specials";
			5: return "streaming";
			default: return "none";
		endcase
	endfunction

	// Exact sum in wide integers, then round to nearest even; returns {flags, result}
	function automatic logic [19:0] modelResult(fpPkg::halfWord x, fpPkg::halfWord y, logic sub);
		int ex;
		int ey;
		int emin;
		int p;
		int e;
		int shift;
		logic sx;
		logic sy;
		logic sign;
		logic up;
		longint vx;
		longint vy;
		longint s;
		longint m;
		longint keep;
		longint rem;
		longint half;
		fpPkg::flagVec f;
		f = '0;
		ex = x[14:10];
		ey = y[14:10];
		sx = x[15];
		sy = y[15] ^ sub;                                  // b as it is added
		if ((ex == 31 && x[9:0] != 0) || (ey == 31 && y[9:0] != 0)
			|| (ex == 31 && ey == 31 && sx != sy)) begin
			f[fpPkg::FlagInvalid] = 1'b1;
			return {f, fpPkg::CanonNaN};
		end
		if (ex == 31)
			return {f, sx, 5'h1f, 10'h0};
		if (ey == 31)
			return {f, sy, 5'h1f, 10'h0};
		vx = (ex == 0) ? 0 : 1024 + x[9:0];                // Exponent zero reads as zero
		vy = (ey == 0) ? 0 : 1024 + y[9:0];
		emin = (ex < ey) ? ex : ey;
		vx = vx << (ex - emin);
		vy = vy << (ey - emin);
		s = (sx ? -vx : vx) + (sy ? -vy : vy);
		if (s == 0)
			return {f, x[15] & y[15] & !sub, 15'h0};        // Minus zero only for -a + -b
		sign = (s < 0);
		m = sign ? -s : s;
		p = 0;
		while ((m >> (p + 1)) != 0)
			p++;
		e = emin + p - 10;                                 // Exponent with leading one on bit 10
		if (e <= 0) begin
			f[fpPkg::FlagUnderflow] = 1'b1;
			f[fpPkg::FlagInexact] = 1'b1;
			return {f, sign, 15'h0};
		end
		if (p > 10) begin
			shift = p - 10;
			keep = m >> shift;
			rem = m & ((longint'(1) << shift) - 1);
			half = longint'(1) << (shift - 1);
			up = (rem > half) || (rem == half && keep[0]);
			f[fpPkg::FlagInexact] = (rem != 0);
			keep = keep + up;
			if (keep == 2048) begin                        // Rounded into the next binade
				keep = 1024;
				e++;
			end
		end else
			keep = m << (10 - p);
		if (e >= 31) begin
			f[fpPkg::FlagOverflow] = 1'b1;
			f[fpPkg::FlagInexact] = 1'b1;
			return {f, sign, 5'h1f, 10'h0};
		end
		return {f, sign, e[4:0], keep[9:0]};
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			pendQ.delete();
			testQ.delete();
			errCount = 0;
			checkCount = 0;
			testChecks = 0;
			testErrs = 0;
		end else begin
			// Pop before push, the entering operation is four edges from its result
			if (outValid) begin
				if (pendQ.size() == 0) begin
					$display("Output appeared with no operation in flight during test %s",
						testName(testNum));
					errCount++;
					testErrs++;
				end else begin
					item = pendQ.pop_front();
					itemTest = testQ.pop_front();
					checkCount++;
					testChecks++;
					if ({flags, result} !== item[19:0]) begin
						$display("ERR %s a=%h b=%h op=%0d expected %h flags %b actual %h flags %b",
							testName(itemTest), item[51:36], item[35:20], item[52],
							item[15:0], item[19:16], result, flags);
						errCount++;
						testErrs++;
					end
				end
			end
			if (inValid) begin
				pendQ.push_back({op, a, b, modelResult(a, b, op)});
				testQ.push_back(testNum);
			end
			if (testDone) begin
				$display("Test %0d %s finished: %0d results, %0d errors",
					testNum, testName(testNum), testChecks, testErrs);
				testChecks = 0;
				testErrs = 0;
			end
			if (finalCheck && pendQ.size() != 0) begin
				$display("%0d operations never produced an output", pendQ.size());
				errCount++;
			end
		end
	end

endmodule

//--- tb/fpAddSubTb.sv
module fpAddSubTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NumTests = 5;
	localparam int TestLen [NumTests] = '{400, 300, 100, 200, 400};  // Slots per test

	logic clk = 1'b0;
	logic rst;
	fpPkg::halfWord a;
	fpPkg::halfWord b;
	logic op;
	logic inValid;
	fpPkg::halfWord result;
	fpPkg::flagVec flags;
	logic outValid;
	int testNum;
	logic testDone;
	logic finalCheck;
	int errCount;
	int checkCount;
	int sent = 0;        // Operations issued
	int received = 0;    // outValid pulses seen
	int cycles = 0;
	int cycleLimit = 0;
	int totalErrors;

	always #5 clk = ~clk;

	fpAddSub dut (.clk, .rst, .a, .b, .op, .inValid, .result, .flags, .outValid);

	fpAddSubChecker resultCheck (
		.clk, .rst, .a, .b, .op, .inValid, .result, .flags, .outValid,
		.testNum, .testDone, .finalCheck, .errCount, .checkCount
	);

	// Cycle count, output count and run limit
	always @(posedge clk) begin
		cycles++;
		if (outValid)
			received++;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic fpPkg::halfWord randNormal();
		return {1'($urandom), 5'(1 + $urandom % 30), 10'($urandom)};
	endfunction

	// NaN, infinity, zero or subnormal, normal
	function automatic fpPkg::halfWord randAnyClass();
		logic [9:0] man;
		man = 10'($urandom);
		case ($urandom % 4)
			0: return {1'($urandom), 5'h1f, man | 10'h1};
			1: return {1'($urandom), 5'h1f, 10'h0};
			2: return {1'($urandom), 5'h00, man};
			default: return randNormal();
		endcase
	endfunction

	task automatic applyOp(input fpPkg::halfWord x, input fpPkg::halfWord y, input logic sub,
		input logic valid);
		@(negedge clk);
		a = x;
		b = y;
		op = sub;
		inValid = valid;
		if (valid)
			sent++;
	endtask

	task automatic runTest(input int n);
		fpPkg::halfWord x;
		fpPkg::halfWord y;
		logic sub;
		logic valid;
		int ex;
		int ey;
		testNum = n;
		for (int i = 0; i < TestLen[n-1]; i++) begin
			valid = 1'b1;
			case (n)
				1: begin
					x = randNormal();
					y = randNormal();
					sub = 1'($urandom);
				end
				2: begin
					// Close and often low exponents to reach flush to zero
					ex = 1 + (($urandom % 2 == 0) ? $urandom % 4 : $urandom % 30);
					ey = ex + int'($urandom % 3) - 1;
					if (ey < 1)
						ey = 1;
					if (ey > 30)
						ey = 30;
					x = {1'($urandom), 5'(ex), 10'($urandom)};
					y = {1'($urandom), 5'(ey),
						(($urandom % 4) == 0) ? x[9:0] : x[9:0] ^ 10'($urandom % 64)};
					sub = 1'b1 ^ x[15] ^ y[15];             // Forces effective subtract
				end
				3: begin
					ex = 28 + $urandom % 3;
					ey = 28 + $urandom % 3;
					x = {1'($urandom), 5'(ex), 10'($urandom) | 10'h200};
					y = {1'($urandom), 5'(ey), 10'($urandom) | 10'h200};
					sub = x[15] ^ y[15];                    // Effective add
				end
				4: begin
					x = randAnyClass();
					y = randAnyClass();
					sub = 1'($urandom);
				end
				default: begin
					x = randNormal();
					y = randAnyClass();
					sub = 1'($urandom);
					valid = ($urandom % 3) != 0;            // Idle gaps
				end
			endcase
			applyOp(x, y, sub, valid);
		end
		@(negedge clk);
		inValid = 1'b0;
		while (received != sent)
			@(negedge clk);
		testDone = 1'b1;
		@(negedge clk);
		testDone = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		a = '0;
		b = '0;
		op = 1'b0;
		inValid = 1'b1;  // Offered during reset and never seen at the output
		testNum = 0;
		testDone = 1'b0;
		finalCheck = 1'b0;
		void'($urandom(9872));
		for (int t = 0; t < NumTests; t++)
			cycleLimit += TestLen[t];
		cycleLimit += NumTests * (fpPkg::PipeDepth + 20) + 100;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		inValid = 1'b0;
		for (int t = 1; t <= NumTests; t++)
			runTest(t);
		finalCheck = 1'b1;
		@(negedge clk);
		finalCheck = 1'b0;
		totalErrors = errCount + dut.assertChecks.failCount;
		$display("Summary: %0d tests, %0d compared, %0d checker errors, %0d assertion failures",
			NumTests, checkCount, errCount, dut.assertChecks.failCount);
		if (totalErrors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- tb/fpAddSub_asserts.sv
module fpAddSubAsserts (
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic outValid,
	input fpPkg::halfWord result,
	input fpPkg::flagVec flags
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;                               // Read by the testbench at the end
	logic [fpPkg::PipeDepth-1:0] rstHist = '1;       // Bit 0 is the last edge

	always @(posedge clk)
		rstHist <= {rstHist[fpPkg::PipeDepth-2:0], rst};

	// Pipeline still flushing right after reset
	quietAfterReset: assert property (@(posedge clk) |rstHist |-> !outValid)
		else begin
			$error("outValid high within four cycles of reset");
			failCount++;
		end

	fixedLatency: assert property (@(posedge clk)
		!(|rstHist) |-> outValid == $past(inValid, fpPkg::PipeDepth))
		else begin
			$error("outValid does not follow inValid by the pipeline depth");
			failCount++;
		end

	// Only one NaN pattern ever leaves the pipe
	canonicalNaN: assert property (@(posedge clk)
		(result[14:10] == 5'h1f && result[9:0] != '0) |-> result == fpPkg::CanonNaN)
		else begin
			$error("NaN result is not the canonical pattern");
			failCount++;
		end

	invalidMeansNaN: assert property (@(posedge clk)
		flags[fpPkg::FlagInvalid] |-> result == fpPkg::CanonNaN)
		else begin
			$error("Invalid flag raised without a NaN result");
			failCount++;
		end

endmodule

bind fpAddSub fpAddSubAsserts assertChecks (.clk, .rst, .inValid, .outValid, .result, .flags);
